// File: hdl/dnc_read_pkg.sv
/*
  DNC read-vector package
  Fixed sizes, element and address widths, counter index types
*/

`default_nettype none

package dnc_read_pkg;

  //////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////

  // Element width, all arithmetic wraps at this width
  localparam int DATA_WIDTH = 16;
  // Read heads
  localparam int SIZE_R     = 2;
  // Memory locations
  localparam int SIZE_N     = 4;
  // Word width in elements
  localparam int SIZE_W     = 3;
  // Flat store address, covers N*W and R*N
  localparam int ADDR_WIDTH = 4;

  //////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // Loop indices, each size assumed to be at least 2
  typedef logic [$clog2(SIZE_R)-1:0] r_idx_t;
  typedef logic [$clog2(SIZE_N)-1:0] n_idx_t;
  typedef logic [$clog2(SIZE_W)-1:0] w_idx_t;

endpackage

`default_nettype wire

// File: hdl/dnc_store_if.sv
/*
  Operand store bus
  Write port from the loader, read port for the engine, load-done pulse
*/

`default_nettype none
`timescale 1ns/100ps

interface dnc_store_if
  import dnc_read_pkg::*;
();

  // Write side
  logic  wr_en;
  // 0 selects the M region, 1 the w region
  logic  wr_sel;
  addr_t wr_addr;
  data_t wr_data;

  // Read side, data returns one cycle after the address
  logic  rd_sel;
  addr_t rd_addr;
  data_t rd_data;

  // Both matrices written
  logic  load_done;

  modport loader (
    output wr_en,
    output wr_sel,
    output wr_addr,
    output wr_data,
    output load_done
  );

  modport store (
    input  wr_en,
    input  wr_sel,
    input  wr_addr,
    input  wr_data,
    input  rd_sel,
    input  rd_addr,
    output rd_data
  );

  modport engine (
    output rd_sel,
    output rd_addr,
    input  rd_data,
    input  load_done
  );

endinterface

`default_nettype wire

// File: hdl/dnc_input_loader.sv
/*
  Input loader for M and w element streams
  Row-marker realignment, flat addressing, load-done when both are complete
*/

`default_nettype none
`timescale 1ns/100ps

module dnc_input_loader
  import dnc_read_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        start,
  input  logic        m_row,
  input  logic        m_elem,
  input  data_t       m_data,
  input  logic        w_row,
  input  logic        w_elem,
  input  data_t       w_data,
  dnc_store_if.loader store
);

  typedef enum logic {ST_IDLE, ST_ARMED} state_t;

  state_t state;
  logic   armed;

  // Next position of each matrix when no marker comes
  addr_t  m_row_q;
  addr_t  m_col_q;
  addr_t  w_row_q;
  addr_t  w_col_q;
  logic   m_full;
  logic   w_full;

  // Target of the incoming element and the position after it
  addr_t  m_tgt_row;
  addr_t  m_tgt_col;
  addr_t  w_tgt_row;
  addr_t  w_tgt_col;
  addr_t  m_row_n;
  addr_t  m_col_n;
  addr_t  w_row_n;
  addr_t  w_col_n;
  logic   m_fits;
  logic   w_fits;
  logic   m_last;
  logic   w_last;
  logic   m_take;
  logic   w_take;
  logic   w_defer;
  addr_t  m_addr;
  addr_t  w_addr;

  // Single-slot hold for a w element that lost the write port
  logic   hold_valid;
  addr_t  hold_addr;
  data_t  hold_data;

  // Marker mid-row moves to column 0 of the next row
  // Marker at column 0 stays, the row was already advanced
  function automatic logic place_elem(
    input  addr_t row_q,
    input  addr_t col_q,
    input  logic  marker,
    input  addr_t last_row,
    output addr_t row,
    output addr_t col
  );
    logic ok;
    ok  = 1'b1;
    row = row_q;
    col = col_q;
    if (marker && (col_q != '0)) begin
      col = '0;
      if (row_q == last_row) begin
        // No row left to realign into
        ok = 1'b0;
      end else begin
        row = row_q + 1'b1;
      end
    end
    return ok;
  endfunction

  // Position after a write, returns 1 on the final element
  function automatic logic step_pos(
    input  addr_t row,
    input  addr_t col,
    input  addr_t last_row,
    input  addr_t last_col,
    output addr_t row_n,
    output addr_t col_n
  );
    logic fin;
    fin   = 1'b0;
    row_n = row;
    col_n = col + 1'b1;
    if (col == last_col) begin
      col_n = '0;
      if (row == last_row) begin
        fin = 1'b1;
      end else begin
        row_n = row + 1'b1;
      end
    end
    return fin;
  endfunction

  //////////////////////////////////////////////////////////////
  // Element placement
  //////////////////////////////////////////////////////////////

  always_comb begin
    m_fits = place_elem(m_row_q, m_col_q, m_row, addr_t'(SIZE_N-1), m_tgt_row, m_tgt_col);
    w_fits = place_elem(w_row_q, w_col_q, w_row, addr_t'(SIZE_R-1), w_tgt_row, w_tgt_col);
    m_last = step_pos(m_tgt_row, m_tgt_col, addr_t'(SIZE_N-1), addr_t'(SIZE_W-1),
                      m_row_n, m_col_n);
    w_last = step_pos(w_tgt_row, w_tgt_col, addr_t'(SIZE_R-1), addr_t'(SIZE_N-1),
                      w_row_n, w_col_n);
    // Row-major flat addresses
    m_addr = m_tgt_row * addr_t'(SIZE_W) + m_tgt_col;
    w_addr = w_tgt_row * addr_t'(SIZE_N) + w_tgt_col;
  end

  assign armed  = (state == ST_ARMED);
  assign m_take = armed && m_elem && !m_full && m_fits;
  // A third element with the hold busy and M writing is dropped
  assign w_take = armed && w_elem && !w_full && w_fits && !(m_take && hold_valid);
  // w waits when M or an older w owns the port
  assign w_defer = w_take && (m_take || hold_valid);

  // Done once both are complete and nothing is waiting
  assign store.load_done = armed && m_full && w_full && !hold_valid;

  //////////////////////////////////////////////////////////////
  // Write port, M first, then held w, then new w
  //////////////////////////////////////////////////////////////

  always_comb begin
    store.wr_en   = 1'b0;
    store.wr_sel  = 1'b0;
    store.wr_addr = m_addr;
    store.wr_data = m_data;
    if (m_take) begin
      store.wr_en = 1'b1;
    end else if (hold_valid) begin
      store.wr_en   = 1'b1;
      store.wr_sel  = 1'b1;
      store.wr_addr = hold_addr;
      store.wr_data = hold_data;
    end else if (w_take) begin
      store.wr_en   = 1'b1;
      store.wr_sel  = 1'b1;
      store.wr_addr = w_addr;
      store.wr_data = w_data;
    end
  end

  //////////////////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= ST_IDLE;
      m_row_q    <= '0;
      m_col_q    <= '0;
      w_row_q    <= '0;
      w_col_q    <= '0;
      m_full     <= 1'b0;
      w_full     <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Arm a fresh run
          if (start) begin
            state      <= ST_ARMED;
            m_row_q    <= '0;
            m_col_q    <= '0;
            w_row_q    <= '0;
            w_col_q    <= '0;
            m_full     <= 1'b0;
            w_full     <= 1'b0;
            hold_valid <= 1'b0;
          end
        end
        ST_ARMED: begin
          if (store.load_done) begin
            state <= ST_IDLE;
          end
          if (m_take) begin
            m_row_q <= m_row_n;
            m_col_q <= m_col_n;
            m_full  <= m_last;
          end
          if (w_take) begin
            w_row_q <= w_row_n;
            w_col_q <= w_col_n;
            w_full  <= w_last;
          end
          // Hold drains whenever M leaves the port free
          if (w_defer) begin
            hold_valid <= 1'b1;
          end else if (!m_take) begin
            hold_valid <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Held w payload
  always_ff @(posedge CLK) begin
    if (w_defer) begin
      hold_addr <= w_addr;
      hold_data <= w_data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/dnc_operand_store.sv
/*
  Operand store for M and w
  One synchronous write port, one registered read port
*/

`default_nettype none
`timescale 1ns/100ps

module dnc_operand_store
  import dnc_read_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  dnc_store_if.store bus
);

  //////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////

  // M at j*W + k
  data_t m_mem [SIZE_N*SIZE_W];
  // w at i*N + j
  data_t w_mem [SIZE_R*SIZE_N];

  // Region select, 1 picks w
  logic  wr_to_w;
  logic  rd_from_w;

  assign wr_to_w   = bus.wr_sel;
  assign rd_from_w = bus.rd_sel;

  //////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////

  // Contents stay between runs
  // A short row leaves the old words in place
  always_ff @(posedge CLK) begin
    if (bus.wr_en) begin
      if (wr_to_w) begin
        w_mem[bus.wr_addr[$clog2(SIZE_R*SIZE_N)-1:0]] <= bus.wr_data;
      end else begin
        m_mem[bus.wr_addr] <= bus.wr_data;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////

  // Data one cycle after the address
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      bus.rd_data <= '0;
    end else if (rd_from_w) begin
      bus.rd_data <= w_mem[bus.rd_addr[$clog2(SIZE_R*SIZE_N)-1:0]];
    end else begin
      bus.rd_data <= m_mem[bus.rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: hdl/dnc_read_engine.sv
/*
  Read engine, r(i,k) = sum over j of M(j,k)*w(i,j)
  Transposed walk over the store, wrapping MAC, strobed output stream
*/

`default_nettype none
`timescale 1ns/100ps

module dnc_read_engine
  import dnc_read_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  dnc_store_if.engine bus,
  output data_t       r_out,
  output logic        r_i_enable,
  output logic        r_k_enable,
  output logic        ready
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH_W,
    ST_FETCH_M,
    ST_ACC,
    ST_DONE
  } state_t;

  state_t state;

  // Loop counters
  r_idx_t i_cnt;
  n_idx_t j_cnt;
  w_idx_t k_cnt;

  // w row of the current head
  data_t  w_row [SIZE_N];
  data_t  acc;
  data_t  acc_sum;
  n_idx_t prod_idx;

  //////////////////////////////////////////////////////////////
  // Read addressing
  //////////////////////////////////////////////////////////////

  // w by row i, M by column k with j walking down the rows
  always_comb begin
    if (state == ST_FETCH_W) begin
      bus.rd_sel  = 1'b1;
      bus.rd_addr = addr_t'(i_cnt) * addr_t'(SIZE_N) + addr_t'(j_cnt);
    end else begin
      bus.rd_sel  = 1'b0;
      bus.rd_addr = addr_t'(j_cnt) * addr_t'(SIZE_W) + addr_t'(k_cnt);
    end
  end

  // Read data lags the address by one, so it belongs to j-1
  // In ST_ACC the last row N-1 arrives
  assign prod_idx = (state == ST_ACC) ? n_idx_t'(SIZE_N-1) : j_cnt - 1'b1;
  assign acc_sum  = acc + w_row[prod_idx] * bus.rd_data;

  //////////////////////////////////////////////////////////////
  // Sequencing and output
  //////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= ST_IDLE;
      i_cnt      <= '0;
      j_cnt      <= '0;
      k_cnt      <= '0;
      r_out      <= '0;
      r_i_enable <= 1'b0;
      r_k_enable <= 1'b0;
      ready      <= 1'b0;
    end else begin
      // Strobes are single pulses
      r_i_enable <= 1'b0;
      r_k_enable <= 1'b0;
      ready      <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (bus.load_done) begin
            state <= ST_FETCH_W;
            i_cnt <= '0;
            j_cnt <= '0;
            k_cnt <= '0;
          end
        end
        ST_FETCH_W: begin
          // N addresses, last word lands in the first M cycle
          if (j_cnt == n_idx_t'(SIZE_N-1)) begin
            j_cnt <= '0;
            k_cnt <= '0;
            state <= ST_FETCH_M;
          end else begin
            j_cnt <= j_cnt + 1'b1;
          end
        end
        ST_FETCH_M: begin
          if (j_cnt == n_idx_t'(SIZE_N-1)) begin
            j_cnt <= '0;
            state <= ST_ACC;
          end else begin
            j_cnt <= j_cnt + 1'b1;
          end
        end
        ST_ACC: begin
          // Last product in, element out
          r_out      <= acc_sum;
          r_k_enable <= 1'b1;
          r_i_enable <= (k_cnt == '0);
          if (k_cnt == w_idx_t'(SIZE_W-1)) begin
            k_cnt <= '0;
            if (i_cnt == r_idx_t'(SIZE_R-1)) begin
              i_cnt <= '0;
              state <= ST_DONE;
            end else begin
              i_cnt <= i_cnt + 1'b1;
              state <= ST_FETCH_W;
            end
          end else begin
            k_cnt <= k_cnt + 1'b1;
            state <= ST_FETCH_M;
          end
        end
        ST_DONE: begin
          // One cycle after the final element strobe
          ready <= 1'b1;
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      ST_FETCH_W: begin
        if (j_cnt != '0) begin
          w_row[j_cnt - 1'b1] <= bus.rd_data;
        end
      end
      ST_FETCH_M: begin
        if (j_cnt == '0) begin
          // New element starts from zero
          acc <= '0;
          // Right after the w fetch, its last word
          if (k_cnt == '0) begin
            w_row[SIZE_N-1] <= bus.rd_data;
          end
        end else begin
          acc <= acc_sum;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/dnc_read_vectors.sv
/*
  DNC read vectors, top level
  Loader, operand store and read engine joined by one store bus
*/

`default_nettype none
`timescale 1ns/100ps

module dnc_read_vectors
  import dnc_read_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,

  // Control
  input  logic  START,
  output logic  READY,

  // M in (j, k) order, w in (i, j) order
  input  logic  M_IN_J_ENABLE,
  input  logic  M_IN_K_ENABLE,
  input  logic  W_IN_I_ENABLE,
  input  logic  W_IN_J_ENABLE,
  // r out in (i, k) order
  output logic  R_OUT_I_ENABLE,
  output logic  R_OUT_K_ENABLE,

  // Data
  input  data_t M_IN,
  input  data_t W_IN,
  output data_t R_OUT
);

  //////////////////////////////////////////////////////////////
  // Store bus
  //////////////////////////////////////////////////////////////

  dnc_store_if store_if ();

  //////////////////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////////////////

  // Row markers map to the loader's row inputs
  dnc_input_loader input_loader_i (
    .CLK    (CLK),
    .RST    (RST),
    .start  (START),
    .m_row  (M_IN_J_ENABLE),
    .m_elem (M_IN_K_ENABLE),
    .m_data (M_IN),
    .w_row  (W_IN_I_ENABLE),
    .w_elem (W_IN_J_ENABLE),
    .w_data (W_IN),
    .store  (store_if.loader)
  );

  dnc_operand_store operand_store_i (
    .CLK (CLK),
    .RST (RST),
    .bus (store_if.store)
  );

  // Transposed MAC and output stream
  dnc_read_engine read_engine_i (
    .CLK        (CLK),
    .RST        (RST),
    .bus        (store_if.engine),
    .r_out      (R_OUT),
    .r_i_enable (R_OUT_I_ENABLE),
    .r_k_enable (R_OUT_K_ENABLE),
    .ready      (READY)
  );

endmodule

`default_nettype wire

// File: test/dnc_read_vectors_sva.sv
/*
  Output strobe and READY assertions for the read-vector top level
*/

`default_nettype none
`timescale 1ns/100ps

module dnc_read_vectors_sva
  import dnc_read_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  READY,
  input  logic  R_OUT_I_ENABLE,
  input  logic  R_OUT_K_ENABLE,
  input  data_t R_OUT
);

  // Element pulses since the last row marker, rows since READY
  int   k_seen;
  int   rows_seen;
  // High in reset and the first cycle after it
  logic rst_q;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      k_seen    <= 0;
      rows_seen <= 0;
      rst_q     <= 1'b1;
    end else begin
      rst_q <= 1'b0;
      if (READY) begin
        k_seen    <= 0;
        rows_seen <= 0;
      end else if (R_OUT_K_ENABLE && R_OUT_I_ENABLE) begin
        k_seen    <= 1;
        rows_seen <= rows_seen + 1;
      end else if (R_OUT_K_ENABLE) begin
        k_seen <= k_seen + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // Reset values
  //////////////////////////////////////////////////////////////

  a_reset_idle: assert property (@(posedge CLK)
    rst_q |-> !READY && !R_OUT_I_ENABLE && !R_OUT_K_ENABLE && (R_OUT == '0))
    else $error("outputs not idle right after reset");

  //////////////////////////////////////////////////////////////
  // Strobe structure
  //////////////////////////////////////////////////////////////

  a_row_has_elem: assert property (@(posedge CLK) disable iff (RST)
    R_OUT_I_ENABLE |-> R_OUT_K_ENABLE)
    else $error("row marker without an element pulse");

  // New row only at run start or after a full row
  a_row_start: assert property (@(posedge CLK) disable iff (RST)
    R_OUT_I_ENABLE |-> (k_seen == 0 && rows_seen == 0) ||
                       (k_seen == SIZE_W && rows_seen < SIZE_R))
    else $error("row marker before the previous row was complete");

  a_elem_in_row: assert property (@(posedge CLK) disable iff (RST)
    R_OUT_K_ENABLE && !R_OUT_I_ENABLE |-> (k_seen != 0) && (k_seen < SIZE_W))
    else $error("element pulse outside a row of the right length");

  // A second READY cycle finds the counters already cleared
  a_ready_after_last: assert property (@(posedge CLK) disable iff (RST)
    READY |-> $past(R_OUT_K_ENABLE) && (k_seen == SIZE_W) && (rows_seen == SIZE_R))
    else $error("READY not right after the last element");

  a_last_gives_ready: assert property (@(posedge CLK) disable iff (RST)
    R_OUT_K_ENABLE && !R_OUT_I_ENABLE && (k_seen == SIZE_W-1) &&
    (rows_seen == SIZE_R) |=> READY)
    else $error("no READY after the last element");

endmodule

bind dnc_read_vectors dnc_read_vectors_sva sva_i (
  .CLK            (CLK),
  .RST            (RST),
  .READY          (READY),
  .R_OUT_I_ENABLE (R_OUT_I_ENABLE),
  .R_OUT_K_ENABLE (R_OUT_K_ENABLE),
  .R_OUT          (R_OUT)
);

`default_nettype wire

// File: test/dnc_read_vectors_tb.sv
/*
  Testbench for the DNC read-vector top level
  LFSR data, behavioral model of M, w and r, checks per run
*/

`default_nettype none
`timescale 1ns/100ps

module dnc_read_vectors_tb
  import dnc_read_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int NUM_RUNS   = 5;
  localparam int M_ELEMS    = SIZE_N*SIZE_W;
  localparam int W_ELEMS    = SIZE_R*SIZE_N;
  localparam int R_ELEMS    = SIZE_R*SIZE_W;
  localparam int WATCHDOG_CYCLES =
    16 + NUM_RUNS*(M_ELEMS + W_ELEMS + R_ELEMS)*(SIZE_N+1) + 200;

  // Load modes
  localparam int MODE_SEQ     = 0;
  localparam int MODE_MIX     = 1;
  localparam int MODE_SHORT   = 2;
  localparam int MODE_RESTART = 3;

  logic  CLK, RST, START, READY;
  logic  M_IN_J_ENABLE, M_IN_K_ENABLE, W_IN_I_ENABLE, W_IN_J_ENABLE;
  logic  R_OUT_I_ENABLE, R_OUT_K_ENABLE;
  data_t M_IN, W_IN, R_OUT;

  // Model of the store contents and write positions
  data_t       m_model [];
  data_t       w_model [];
  int          m_r, m_c, w_r, w_c;
  data_t       got [$];
  int          ready_seen;
  logic [15:0] lfsr;

  dnc_read_vectors dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever begin
      #(CLK_PERIOD/2);
      CLK = ~CLK;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES*CLK_PERIOD);
    $display("Timeout: runs did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $fatal(1, "watchdog");
  end

  // Output capture, registered outputs are stable here
  always @(negedge CLK) begin
    if (!RST) begin
      if (R_OUT_K_ENABLE) begin
        got.push_back(R_OUT);
      end
      if (READY) begin
        ready_seen++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic random_data(output data_t v);
    v = '0;
    for (int b = 0; b < DATA_WIDTH; b++) begin
      v    = {v[DATA_WIDTH-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_equal(input string test, input string what,
                             input int expected, input int actual);
    assert (actual == expected) else begin
      $display("** Error [%s] %s: expected %0h, actual %0h", test, what, expected, actual);
      $display("Checks failed");
      $fatal(1, "first error");
    end
  endtask

  // Marker mid-row jumps to column 0 of the next row
  task automatic place_m(input logic mark, input data_t v);
    if (mark && m_c != 0) begin
      m_c = 0;
      m_r = m_r + 1;
    end
    m_model[m_r*SIZE_W + m_c] = v;
    m_c = m_c + 1;
    if (m_c == SIZE_W) begin
      m_c = 0;
      m_r = m_r + 1;
    end
  endtask

  task automatic place_w(input logic mark, input data_t v);
    if (mark && w_c != 0) begin
      w_c = 0;
      w_r = w_r + 1;
    end
    w_model[w_r*SIZE_N + w_c] = v;
    w_c = w_c + 1;
    if (w_c == SIZE_N) begin
      w_c = 0;
      w_r = w_r + 1;
    end
  endtask

  // One cycle of stimulus, START falls back to low
  task automatic drive_cycle(input logic mv, input logic mm, input data_t md,
                             input logic wv, input logic wm, input data_t wd);
    @(negedge CLK);
    START         = 1'b0;
    M_IN_K_ENABLE = mv;
    M_IN_J_ENABLE = mv && mm;
    M_IN          = md;
    W_IN_J_ENABLE = wv;
    W_IN_I_ENABLE = wv && wm;
    W_IN          = wd;
    if (mv) begin
      place_m(mm, md);
    end
    if (wv) begin
      place_w(wm, wd);
    end
  endtask

  task automatic idle_cycle;
    drive_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic begin_run;
    got.delete();
    ready_seen = 0;
    m_r = 0;
    m_c = 0;
    w_r = 0;
    w_c = 0;
    idle_cycle();
    START = 1'b1;
    idle_cycle();
  endtask

  // All of M, then all of w, optional gap in row 1 of M
  task automatic load_sequential(input logic short_row, input logic extra_start);
    data_t v;
    for (int j = 0; j < SIZE_N; j++) begin
      for (int k = 0; k < SIZE_W; k++) begin
        if (!(short_row && j == 1 && k == SIZE_W-1)) begin
          random_data(v);
          drive_cycle(1'b1, k == 0, v, 1'b0, 1'b0, '0);
        end
      end
    end
    if (extra_start) begin
      // Loader is armed, this pulse must be ignored
      idle_cycle();
      START = 1'b1;
    end
    for (int i = 0; i < SIZE_R; i++) begin
      for (int j = 0; j < SIZE_N; j++) begin
        random_data(v);
        drive_cycle(1'b0, 1'b0, '0, 1'b1, j == 0, v);
      end
    end
  endtask

  // Slot pattern M+w, idle, M only, so a held w always drains
  task automatic load_interleaved;
    data_t md;
    data_t wd;
    int    mi;
    int    wi;
    int    slot;
    logic  use_m;
    logic  use_w;
    mi   = 0;
    wi   = 0;
    slot = 0;
    while (mi < M_ELEMS || wi < W_ELEMS) begin
      use_m = (slot % 3 != 1) && (mi < M_ELEMS);
      use_w = (wi < W_ELEMS) && ((slot % 3 == 0) || (mi >= M_ELEMS));
      md    = '0;
      wd    = '0;
      if (use_m) begin
        random_data(md);
      end
      if (use_w) begin
        random_data(wd);
      end
      drive_cycle(use_m, (mi % SIZE_W) == 0, md, use_w, (wi % SIZE_N) == 0, wd);
      if (use_m) begin
        mi++;
      end
      if (use_w) begin
        wi++;
      end
      slot++;
    end
  endtask

  // r(i,k) = sum over j of M(j,k)*w(i,j), 16-bit wrap
  function automatic data_t expected_r(input int i, input int k);
    data_t acc;
    acc = '0;
    for (int j = 0; j < SIZE_N; j++) begin
      acc = acc + m_model[j*SIZE_W + k] * w_model[i*SIZE_N + j];
    end
    return acc;
  endfunction

  ////////////////////////////////////////////////////////////
  // One run, load, wait for READY, compare
  ////////////////////////////////////////////////////////////

  task automatic run_test(input string name, input int mode);
    begin_run();
    if (mode == MODE_MIX) begin
      load_interleaved();
    end else begin
      load_sequential(mode == MODE_SHORT, mode == MODE_RESTART);
    end
    idle_cycle();
    if (mode == MODE_RESTART) begin
      // Second START while the engine streams
      while (got.size() == 0) begin
        @(negedge CLK);
      end
      START = 1'b1;
      idle_cycle();
    end
    while (ready_seen == 0) begin
      @(negedge CLK);
    end
    // Quiet window to catch stray strobes after READY
    repeat (2*(SIZE_N+1)) @(negedge CLK);
    check_equal(name, "output count", R_ELEMS, got.size());
    check_equal(name, "READY pulses", 1, ready_seen);
    for (int i = 0; i < SIZE_R; i++) begin
      for (int k = 0; k < SIZE_W; k++) begin
        check_equal(name, $sformatf("r(%0d,%0d)", i, k),
                    int'(expected_r(i, k)), int'(got[i*SIZE_W + k]));
      end
    end
  endtask

  initial begin
    RST           = 1'b1;
    START         = 1'b0;
    M_IN_J_ENABLE = 1'b0;
    M_IN_K_ENABLE = 1'b0;
    W_IN_I_ENABLE = 1'b0;
    W_IN_J_ENABLE = 1'b0;
    M_IN          = '0;
    W_IN          = '0;
    lfsr          = 16'd60994;
    ready_seen    = 0;
    m_model       = new[M_ELEMS];
    w_model       = new[W_ELEMS];
    repeat (16) @(negedge CLK);
    RST = 1'b0;

    run_test("sequential load", MODE_SEQ);
    run_test("interleaved load", MODE_MIX);
    // Relies on M(1,2) from the run before
    run_test("short row realign", MODE_SHORT);
    run_test("start during run", MODE_RESTART);
    run_test("second run", MODE_SEQ);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hdl/dnc_read_pkg.sv
hdl/dnc_store_if.sv
hdl/dnc_input_loader.sv
hdl/dnc_operand_store.sv
hdl/dnc_read_engine.sv
hdl/dnc_read_vectors.sv
test/dnc_read_vectors_sva.sv
test/dnc_read_vectors_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Verilator build and run of the read-vector testbench
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -sv \
  --top-module dnc_read_vectors_tb -f filelist.f \
  || { echo "FAIL: build error"; exit 1; }

./obj_dir/Vdnc_read_vectors_tb 2>&1 | tee "$LOG"

# The log decides the result
grep -q "Checks failed" "$LOG" \
  && { echo "FAIL: see $LOG"; exit 1; } \
  || { echo "PASS"; exit 0; }
